/* src/dacfifo_params.svh */
// avl width must equal dma width times words per beat; each buffer must hold at least one burst
`ifndef DACFIFO_PARAMS_SVH
`define DACFIFO_PARAMS_SVH

// word and beat widths
`define DACFIFO_DMA_WIDTH       32
`define DACFIFO_AVL_WIDTH       128
`define DACFIFO_WORDS_PER_BEAT  4

// memory addressing, in beats
`define DACFIFO_AVL_ADDR_WIDTH  10
`define DACFIFO_BASE_ADDR       0

// burst and local buffer sizes
`define DACFIFO_BURST_LEN       4
`define DACFIFO_BUF_DEPTH       8

`endif

/* src/dacfifo_pkg.sv */
// types only; every width here follows the dacfifo_params.svh macros
`include "dacfifo_params.svh"

package dacfifo_pkg;

  // one sample as it arrives from the DMA or leaves to the DAC
  typedef logic [`DACFIFO_DMA_WIDTH-1:0] sample_t;

  // one Avalon data beat and its byte enable
  typedef logic [`DACFIFO_AVL_WIDTH-1:0] beat_t;
  typedef logic [`DACFIFO_AVL_WIDTH/8-1:0] byte_en_t;

  // beat address and burst count, burst count runs 1 to burst length
  typedef logic [`DACFIFO_AVL_ADDR_WIDTH-1:0] avl_addr_t;
  typedef logic [$clog2(`DACFIFO_BURST_LEN):0] burst_cnt_t;

  // word slot inside a beat
  typedef logic [$clog2(`DACFIFO_WORDS_PER_BEAT)-1:0] word_idx_t;

  // transfer phase of the whole buffer
  typedef enum logic [1:0] {
    idle,
    load,
    play
  } xfer_phase_t;

endpackage

/* src/dacfifo_wr.sv */
// source must idle a cycle between words and ready must average one cycle in four, else the beat buffer overflows
`timescale 1ns/1ps
`include "dacfifo_params.svh"

module dacfifo_wr import dacfifo_pkg::*; (
  input  logic       avl_clk,
  input  logic       avl_reset,
  input  logic       dma_xfer_req,
  input  logic       dma_valid,
  input  sample_t    dma_data,
  input  logic       dma_xfer_last,
  input  logic       avl_ready,
  output avl_addr_t  wr_address,
  output burst_cnt_t wr_burstcount,
  output byte_en_t   wr_byteenable,
  output logic       wr_write,
  output beat_t      wr_data,
  output logic       wr_done,
  output avl_addr_t  wr_last_address,
  output byte_en_t   wr_last_byteenable
);

  localparam int bytes_per_word = `DACFIFO_DMA_WIDTH / 8;
  localparam int ptr_w = $clog2(`DACFIFO_BUF_DEPTH);

  logic             xfer_req_d;
  logic             load_start;
  logic             word_take;
  logic             beat_push;
  logic             beat_accept;
  logic             last_pending;
  logic             final_beat;
  logic             burst_start;
  burst_cnt_t       burst_len;
  burst_cnt_t       beats_left;
  word_idx_t        word_idx;
  beat_t            pack_data;
  beat_t            pack_next;
  byte_en_t         last_be;
  byte_en_t         last_be_next;
  beat_t            buf_mem [`DACFIFO_BUF_DEPTH];
  logic [ptr_w-1:0] buf_wr_ptr;
  logic [ptr_w-1:0] buf_rd_ptr;
  logic [ptr_w:0]   buf_level;
  logic             last_seen;

  // ********************************************************
  // word packing
  // ********************************************************

  assign load_start = dma_xfer_req && !xfer_req_d;
  assign word_take  = dma_valid && !load_start;
  assign beat_push  = word_take &&
                      ((word_idx == word_idx_t'(`DACFIFO_WORDS_PER_BEAT - 1)) || dma_xfer_last);

  always_comb begin
    pack_next = pack_data;
    pack_next[word_idx*`DACFIFO_DMA_WIDTH +: `DACFIFO_DMA_WIDTH] = dma_data;
  end

  // words up to and including the current slot are enabled
  always_comb begin
    last_be_next = '0;
    for (int w = 0; w < `DACFIFO_WORDS_PER_BEAT; w++) begin
      if (w <= int'(word_idx)) begin
        last_be_next[w*bytes_per_word +: bytes_per_word] = '1;
      end
    end
  end

  // ********************************************************
  // burst sequencer
  // ********************************************************

  assign burst_start  = !wr_write && !load_start &&
                        ((buf_level >= `DACFIFO_BURST_LEN) || (last_seen && buf_level != 0));
  assign burst_len    = (buf_level >= `DACFIFO_BURST_LEN) ? burst_cnt_t'(`DACFIFO_BURST_LEN) :
                                                            burst_cnt_t'(buf_level);
  assign beat_accept  = wr_write && avl_ready;
  assign last_pending = last_seen && (buf_level == 1);
  assign final_beat   = beat_accept && last_pending;

  assign wr_data       = buf_mem[buf_rd_ptr];
  assign wr_byteenable = last_pending ? last_be : '1;

  always_ff @(posedge avl_clk) begin
    if (avl_reset) begin
      xfer_req_d    <= 1'b0;
      word_idx      <= '0;
      buf_wr_ptr    <= '0;
      buf_rd_ptr    <= '0;
      buf_level     <= '0;
      last_seen     <= 1'b0;
      wr_write      <= 1'b0;
      wr_address    <= avl_addr_t'(`DACFIFO_BASE_ADDR);
      wr_burstcount <= '0;
      beats_left    <= '0;
      wr_done       <= 1'b0;
    end else begin
      xfer_req_d <= dma_xfer_req;
      wr_done    <= final_beat;
      if (load_start) begin
        word_idx   <= '0;
        buf_wr_ptr <= '0;
        buf_rd_ptr <= '0;
        buf_level  <= '0;
        last_seen  <= 1'b0;
        wr_write   <= 1'b0;
        wr_address <= avl_addr_t'(`DACFIFO_BASE_ADDR);
      end else begin
        if (word_take) begin
          word_idx <= beat_push ? '0 : word_idx + 1'b1;
        end
        if (beat_push) begin
          buf_wr_ptr <= buf_wr_ptr + 1'b1;
          last_seen  <= dma_xfer_last;
        end
        if (beat_accept) begin
          buf_rd_ptr <= buf_rd_ptr + 1'b1;
        end
        case ({beat_push, beat_accept})
          2'b10:   buf_level <= buf_level + 1'b1;
          2'b01:   buf_level <= buf_level - 1'b1;
          default: buf_level <= buf_level;
        endcase
        if (burst_start) begin
          wr_write      <= 1'b1;
          wr_burstcount <= burst_len;
          beats_left    <= burst_len;
        end else if (beat_accept) begin
          beats_left <= beats_left - 1'b1;
          // burst done, next one starts right after it
          if (beats_left == 1) begin
            wr_write   <= 1'b0;
            wr_address <= wr_address + avl_addr_t'(wr_burstcount);
          end
        end
      end
    end
  end

  // payload storage
  always_ff @(posedge avl_clk) begin
    if (word_take) begin
      pack_data <= beat_push ? '0 : pack_next;
    end
    if (beat_push) begin
      buf_mem[buf_wr_ptr] <= pack_next;
    end
    if (beat_push && dma_xfer_last) begin
      last_be <= last_be_next;
    end
    if (final_beat) begin
      wr_last_address    <= wr_address + avl_addr_t'(wr_burstcount) - 1'b1;
      wr_last_byteenable <= last_be;
    end
  end

endmodule

/* src/dacfifo_rd.sv */
// plays the stored waveform in a loop from the base address; returns of reads issued before play_en fell are dropped
`timescale 1ns/1ps
`include "dacfifo_params.svh"

module dacfifo_rd import dacfifo_pkg::*; (
  input  logic       avl_clk,
  input  logic       avl_reset,
  input  logic       play_en,
  input  avl_addr_t  last_address,
  input  byte_en_t   last_byteenable,
  input  logic       avl_ready,
  input  beat_t      avl_readdata,
  input  logic       avl_readdata_valid,
  input  logic       dac_valid,
  output avl_addr_t  rd_address,
  output burst_cnt_t rd_burstcount,
  output logic       rd_read,
  output sample_t    dac_data,
  output logic       dac_dunf
);

  localparam int bytes_per_word = `DACFIFO_DMA_WIDTH / 8;
  localparam int ptr_w = $clog2(`DACFIFO_BUF_DEPTH);
  localparam int level_w = ptr_w + 1;

  logic               cmd_accept;
  logic               burst_wraps;
  logic               room;
  avl_addr_t          remaining;
  burst_cnt_t         burst_len;
  logic [level_w-1:0] inflight;
  logic [level_w-1:0] inflight_next;
  logic               draining;
  avl_addr_t          rtn_addr;
  logic               beat_store;
  beat_t              buf_mem [`DACFIFO_BUF_DEPTH];
  logic               last_flag [`DACFIFO_BUF_DEPTH];
  logic [ptr_w-1:0]   buf_wr_ptr;
  logic [ptr_w-1:0]   buf_rd_ptr;
  logic [level_w-1:0] buf_level;
  beat_t              cur_beat;
  word_idx_t          word_sel;
  word_idx_t          next_word;
  logic               beat_end;
  logic               word_pop;
  logic               beat_pop;

  // ********************************************************
  // burst fetch with credit for requested beats
  // ********************************************************

  assign cmd_accept  = rd_read && avl_ready && play_en;
  assign remaining   = last_address - rd_address;
  assign burst_len   = (remaining >= `DACFIFO_BURST_LEN - 1) ? burst_cnt_t'(`DACFIFO_BURST_LEN) :
                                                              burst_cnt_t'(remaining + 1'b1);
  assign burst_wraps = (rd_address + avl_addr_t'(rd_burstcount) - 1'b1) == last_address;
  // a full burst must fit next to what is held and what is on its way
  assign room        = (buf_level + inflight) <= (`DACFIFO_BUF_DEPTH - `DACFIFO_BURST_LEN);

  // counts every return, kept or dropped
  always_comb begin
    inflight_next = inflight;
    if (cmd_accept) begin
      inflight_next = inflight_next + level_w'(rd_burstcount);
    end
    if (avl_readdata_valid) begin
      inflight_next = inflight_next - 1'b1;
    end
  end

  assign beat_store = avl_readdata_valid && play_en && !draining;

  // ********************************************************
  // word unpacking
  // ********************************************************

  assign cur_beat  = buf_mem[buf_rd_ptr];
  assign next_word = word_sel + 1'b1;
  // the last beat of the waveform may end early
  assign beat_end  = (word_sel == word_idx_t'(`DACFIFO_WORDS_PER_BEAT - 1)) ||
                     (last_flag[buf_rd_ptr] && !last_byteenable[int'(next_word) * bytes_per_word]);
  assign word_pop  = dac_valid && play_en && (buf_level != 0);
  assign beat_pop  = word_pop && beat_end;

  always_ff @(posedge avl_clk) begin
    if (avl_reset) begin
      inflight      <= '0;
      draining      <= 1'b0;
      rd_read       <= 1'b0;
      rd_address    <= avl_addr_t'(`DACFIFO_BASE_ADDR);
      rd_burstcount <= '0;
      rtn_addr      <= avl_addr_t'(`DACFIFO_BASE_ADDR);
      buf_wr_ptr    <= '0;
      buf_rd_ptr    <= '0;
      buf_level     <= '0;
      word_sel      <= '0;
      dac_dunf      <= 1'b0;
    end else begin
      inflight <= inflight_next;
      dac_dunf <= dac_valid && !word_pop;
      if (!play_en) begin
        draining   <= 1'b1;
        rd_read    <= 1'b0;
        rd_address <= avl_addr_t'(`DACFIFO_BASE_ADDR);
        rtn_addr   <= avl_addr_t'(`DACFIFO_BASE_ADDR);
        buf_wr_ptr <= '0;
        buf_rd_ptr <= '0;
        buf_level  <= '0;
        word_sel   <= '0;
      end else begin
        if (draining && inflight == 0) begin
          draining <= 1'b0;
        end
        if (cmd_accept) begin
          rd_read    <= 1'b0;
          rd_address <= burst_wraps ? avl_addr_t'(`DACFIFO_BASE_ADDR) :
                                      rd_address + avl_addr_t'(rd_burstcount);
        end else if (!rd_read && !draining && room) begin
          rd_read       <= 1'b1;
          rd_burstcount <= burst_len;
        end
        if (beat_store) begin
          buf_wr_ptr <= buf_wr_ptr + 1'b1;
          rtn_addr   <= (rtn_addr == last_address) ? avl_addr_t'(`DACFIFO_BASE_ADDR) :
                                                     rtn_addr + 1'b1;
        end
        if (word_pop) begin
          word_sel <= beat_end ? '0 : next_word;
        end
        if (beat_pop) begin
          buf_rd_ptr <= buf_rd_ptr + 1'b1;
        end
        case ({beat_store, beat_pop})
          2'b10:   buf_level <= buf_level + 1'b1;
          2'b01:   buf_level <= buf_level - 1'b1;
          default: buf_level <= buf_level;
        endcase
      end
    end
  end

  // beat storage and output word, dac_data holds on underflow
  always_ff @(posedge avl_clk) begin
    if (beat_store) begin
      buf_mem[buf_wr_ptr]   <= avl_readdata;
      last_flag[buf_wr_ptr] <= (rtn_addr == last_address);
    end
    if (word_pop) begin
      dac_data <= cur_beat[word_sel*`DACFIFO_DMA_WIDTH +: `DACFIFO_DMA_WIDTH];
    end
  end

endmodule

/* src/dacfifo_xfer_ctrl.sv */
// a dma_xfer_req rise always restarts the load, even in the middle of play; reads use full byte enable
`timescale 1ns/1ps

module dacfifo_xfer_ctrl import dacfifo_pkg::*; (
  input  logic       avl_clk,
  input  logic       avl_reset,
  input  logic       dma_xfer_req,
  input  logic       wr_done,
  input  avl_addr_t  wr_last_address,
  input  byte_en_t   wr_last_byteenable,
  input  avl_addr_t  wr_address,
  input  burst_cnt_t wr_burstcount,
  input  byte_en_t   wr_byteenable,
  input  logic       wr_write,
  input  beat_t      wr_data,
  input  avl_addr_t  rd_address,
  input  burst_cnt_t rd_burstcount,
  input  logic       rd_read,
  output logic       play_en,
  output avl_addr_t  last_address,
  output byte_en_t   last_byteenable,
  output logic       dac_xfer_out,
  output avl_addr_t  avl_address,
  output burst_cnt_t avl_burstcount,
  output byte_en_t   avl_byteenable,
  output logic       avl_read,
  output logic       avl_write,
  output beat_t      avl_writedata
);

  xfer_phase_t phase;
  logic        xfer_req_d;

  // phase FSM
  always_ff @(posedge avl_clk) begin
    if (avl_reset) begin
      phase      <= idle;
      xfer_req_d <= 1'b0;
    end else begin
      xfer_req_d <= dma_xfer_req;
      if (dma_xfer_req && !xfer_req_d) begin
        phase <= load;
      end else if (wr_done && phase == load) begin
        phase <= play;
      end
    end
  end

  // waveform length as reported by the writer
  always_ff @(posedge avl_clk) begin
    if (wr_done) begin
      last_address    <= wr_last_address;
      last_byteenable <= wr_last_byteenable;
    end
  end

  assign play_en      = (phase == play);
  assign dac_xfer_out = play_en;

  // ********************************************************
  // Avalon port, writer in load and reader in play
  // ********************************************************

  assign avl_address    = play_en ? rd_address : wr_address;
  assign avl_burstcount = play_en ? rd_burstcount : wr_burstcount;
  assign avl_byteenable = play_en ? '1 : wr_byteenable;
  assign avl_read       = play_en && rd_read;
  assign avl_write      = (phase == load) && wr_write;
  assign avl_writedata  = wr_data;

endmodule

/* src/avl_dacfifo.sv */
// single avl_clk domain; DMA and DAC strobes have no back-pressure and memory must hold the whole waveform
`timescale 1ns/1ps

module avl_dacfifo import dacfifo_pkg::*; (
  input  logic       avl_clk,
  input  logic       avl_reset,

  // DMA side
  input  logic       dma_xfer_req,
  input  logic       dma_valid,
  input  sample_t    dma_data,
  input  logic       dma_xfer_last,

  // DAC side
  input  logic       dac_valid,
  output sample_t    dac_data,
  output logic       dac_dunf,
  output logic       dac_xfer_out,

  // Avalon memory port
  output avl_addr_t  avl_address,
  output burst_cnt_t avl_burstcount,
  output byte_en_t   avl_byteenable,
  output logic       avl_read,
  input  beat_t      avl_readdata,
  input  logic       avl_readdata_valid,
  input  logic       avl_ready,
  output logic       avl_write,
  output beat_t      avl_writedata
);

  avl_addr_t  wr_address;
  burst_cnt_t wr_burstcount;
  byte_en_t   wr_byteenable;
  logic       wr_write;
  beat_t      wr_data;
  logic       wr_done;
  avl_addr_t  wr_last_address;
  byte_en_t   wr_last_byteenable;
  logic       play_en;
  avl_addr_t  last_address;
  byte_en_t   last_byteenable;
  avl_addr_t  rd_address;
  burst_cnt_t rd_burstcount;
  logic       rd_read;

  dacfifo_wr i_wr (
    .avl_clk            (avl_clk),
    .avl_reset          (avl_reset),
    .dma_xfer_req       (dma_xfer_req),
    .dma_valid          (dma_valid),
    .dma_data           (dma_data),
    .dma_xfer_last      (dma_xfer_last),
    .avl_ready          (avl_ready),
    .wr_address         (wr_address),
    .wr_burstcount      (wr_burstcount),
    .wr_byteenable      (wr_byteenable),
    .wr_write           (wr_write),
    .wr_data            (wr_data),
    .wr_done            (wr_done),
    .wr_last_address    (wr_last_address),
    .wr_last_byteenable (wr_last_byteenable)
  );

  dacfifo_rd i_rd (
    .avl_clk            (avl_clk),
    .avl_reset          (avl_reset),
    .play_en            (play_en),
    .last_address       (last_address),
    .last_byteenable    (last_byteenable),
    .avl_ready          (avl_ready),
    .avl_readdata       (avl_readdata),
    .avl_readdata_valid (avl_readdata_valid),
    .dac_valid          (dac_valid),
    .rd_address         (rd_address),
    .rd_burstcount      (rd_burstcount),
    .rd_read            (rd_read),
    .dac_data           (dac_data),
    .dac_dunf           (dac_dunf)
  );

  dacfifo_xfer_ctrl i_ctrl (
    .avl_clk            (avl_clk),
    .avl_reset          (avl_reset),
    .dma_xfer_req       (dma_xfer_req),
    .wr_done            (wr_done),
    .wr_last_address    (wr_last_address),
    .wr_last_byteenable (wr_last_byteenable),
    .wr_address         (wr_address),
    .wr_burstcount      (wr_burstcount),
    .wr_byteenable      (wr_byteenable),
    .wr_write           (wr_write),
    .wr_data            (wr_data),
    .rd_address         (rd_address),
    .rd_burstcount      (rd_burstcount),
    .rd_read            (rd_read),
    .play_en            (play_en),
    .last_address       (last_address),
    .last_byteenable    (last_byteenable),
    .dac_xfer_out       (dac_xfer_out),
    .avl_address        (avl_address),
    .avl_burstcount     (avl_burstcount),
    .avl_byteenable     (avl_byteenable),
    .avl_read           (avl_read),
    .avl_write          (avl_write),
    .avl_writedata      (avl_writedata)
  );

endmodule

/* test/avl_mem_model.sv */
// behavioral burst memory; ready is random at a percent duty and read beats return 1 to 4 cycles apart
`timescale 1ns/1ps

module avl_mem_model import dacfifo_pkg::*; (
  input  logic       avl_clk,
  input  logic       avl_reset,
  input  logic       fill_req,
  input  logic [7:0] ready_duty,
  input  avl_addr_t  avl_address,
  input  burst_cnt_t avl_burstcount,
  input  byte_en_t   avl_byteenable,
  input  logic       avl_read,
  input  logic       avl_write,
  input  beat_t      avl_writedata,
  output logic       avl_ready,
  output beat_t      avl_readdata,
  output logic       avl_readdata_valid
);

  localparam int depth  = 2 ** $bits(avl_addr_t);
  localparam int word_w = $bits(sample_t);
  localparam int words  = $bits(beat_t) / word_w;

  beat_t     mem_array [depth];
  avl_addr_t rd_q [$];
  avl_addr_t wr_addr;
  int        wr_left;
  int        rd_gap;
  int        a;
  int        w;
  int        i;
  int        b;

  // every word of the background differs, so a stray write or read shows up
  function automatic sample_t fill_pattern(input int beat, input int word);
    return 32'hf00d_0000 ^ sample_t'(beat * words + word);
  endfunction

  initial begin
    avl_ready          = 1'b0;
    avl_readdata       = '0;
    avl_readdata_valid = 1'b0;
  end

  always @(posedge avl_clk) begin
    if (avl_reset) begin
      avl_ready          <= 1'b0;
      avl_readdata_valid <= 1'b0;
      wr_left = 0;
      rd_gap  = 0;
      rd_q.delete();
    end else begin
      avl_ready          <= ($urandom % 100) < ready_duty;
      avl_readdata_valid <= 1'b0;
      if (fill_req) begin
        for (a = 0; a < depth; a++) begin
          for (w = 0; w < words; w++) begin
            mem_array[a][w*word_w +: word_w] = fill_pattern(a, w);
          end
        end
      end
      // one return per gap, in request order
      if (rd_q.size() != 0) begin
        if (rd_gap == 0) begin
          avl_readdata       <= mem_array[rd_q.pop_front()];
          avl_readdata_valid <= 1'b1;
          rd_gap = $urandom_range(3, 0);
        end else begin
          rd_gap--;
        end
      end
      if (avl_read && avl_ready) begin
        for (i = 0; i < int'(avl_burstcount); i++) begin
          rd_q.push_back(avl_address + avl_addr_t'(i));
        end
      end
      // address is taken from the first beat of each write burst
      if (avl_write && avl_ready) begin
        if (wr_left == 0) begin
          wr_addr = avl_address;
          wr_left = int'(avl_burstcount);
        end
        for (b = 0; b < $bits(byte_en_t); b++) begin
          if (avl_byteenable[b]) begin
            mem_array[wr_addr][b*8 +: 8] = avl_writedata[b*8 +: 8];
          end
        end
        wr_addr++;
        wr_left--;
      end
    end
  end

endmodule

/* test/tb_avl_dacfifo.sv */
// cases come from test/dacfifo_cases.txt; every load after the first starts while the last one plays
`timescale 1ns/1ps

module tb_avl_dacfifo import dacfifo_pkg::*; ();

  localparam int wait_limit = 4000;
  localparam int word_w = $bits(sample_t);
  localparam int words = $bits(beat_t) / word_w;

  logic       avl_clk;
  logic       avl_reset;
  logic       dma_xfer_req;
  logic       dma_valid;
  sample_t    dma_data;
  logic       dma_xfer_last;
  logic       dac_valid;
  sample_t    dac_data;
  logic       dac_dunf;
  logic       dac_xfer_out;
  avl_addr_t  avl_address;
  burst_cnt_t avl_burstcount;
  byte_en_t   avl_byteenable;
  logic       avl_read;
  logic       avl_write;
  beat_t      avl_writedata;
  logic       avl_ready;
  beat_t      avl_readdata;
  logic       avl_readdata_valid;
  logic       fill_req;
  logic [7:0] ready_duty;

  logic [8*16-1:0] case_name;
  logic [8*80-1:0] line_buf;
  int              word_count;
  sample_t         first_word;
  int              duty_in;
  int              req_count;
  int              fd;
  int              case_total;

  avl_dacfifo UUT (.*);

  avl_mem_model i_mem (.*);

  always #2 avl_clk = ~avl_clk;

  // ************************************************************
  // failure handling
  // ************************************************************

  task automatic flag_mismatch(input string check, input logic [127:0] expected,
                               input logic [127:0] actual);
    $display("ERROR case %0s %s expected %0h actual %0h", case_name, check, expected, actual);
    $display("ERRORS FOUND");
    $fatal(1, "value mismatch");
  endtask

  task automatic abort_run(input string text);
    $display("%s", text);
    $display("ERRORS FOUND");
    $fatal(1, "run stopped");
  endtask

  function automatic sample_t background_word(input int beat, input int word);
    return 32'hf00d_0000 ^ sample_t'(beat * words + word);
  endfunction

  // ************************************************************
  // stimulus
  // ************************************************************

  task automatic load_waveform();
    int k;
    @(posedge avl_clk);
    fill_req     <= 1'b1;
    dma_xfer_req <= 1'b0;
    @(posedge avl_clk);
    fill_req <= 1'b0;
    @(posedge avl_clk);
    dma_xfer_req <= 1'b1;
    repeat (2) @(posedge avl_clk);
    for (k = 0; k < word_count; k++) begin
      dma_valid     <= 1'b1;
      dma_data      <= first_word + sample_t'(k);
      dma_xfer_last <= (k == word_count - 1);
      @(posedge avl_clk);
      dma_valid     <= 1'b0;
      dma_xfer_last <= 1'b0;
      @(posedge avl_clk);
    end
  endtask

  task automatic wait_for_play();
    int waited;
    waited = 0;
    while (!dac_xfer_out && waited < wait_limit) begin
      @(negedge avl_clk);
      waited++;
    end
    if (!dac_xfer_out) begin
      abort_run($sformatf("timeout: case %0s never reached playback", case_name));
    end
  endtask

  // packed words in order, untouched background around and after them
  task automatic check_memory();
    int      beat;
    int      word;
    int      idx;
    sample_t got;
    sample_t exp;
    for (beat = 0; beat < (word_count + words - 1) / words + 2; beat++) begin
      for (word = 0; word < words; word++) begin
        idx = beat * words + word;
        got = i_mem.mem_array[beat][word*word_w +: word_w];
        exp = (idx < word_count) ? first_word + sample_t'(idx) : background_word(beat, word);
        assert (got === exp)
          else flag_mismatch($sformatf("memory beat %0d word %0d", beat, word), exp, got);
      end
    end
  endtask

  task automatic play_and_check();
    int      r;
    int      exp_idx;
    int      good;
    sample_t prev_data;
    sample_t exp_word;
    prev_data = dac_data;
    exp_idx   = 0;
    good      = 0;
    for (r = 0; r < req_count; r++) begin
      @(posedge avl_clk);
      dac_valid <= 1'b1;
      // cycle with no request in front of it
      @(negedge avl_clk);
      assert (dac_dunf === 1'b0) else flag_mismatch("idle dac_dunf", 0, dac_dunf);
      assert (dac_data === prev_data) else flag_mismatch("idle dac_data", prev_data, dac_data);
      @(posedge avl_clk);
      dac_valid <= 1'b0;
      @(negedge avl_clk);
      if (dac_dunf === 1'b1) begin
        assert (dac_data === prev_data)
          else flag_mismatch("dac_data on underflow", prev_data, dac_data);
      end else begin
        exp_word = first_word + sample_t'(exp_idx);
        assert (dac_data === exp_word)
          else flag_mismatch($sformatf("dac word %0d", exp_idx), exp_word, dac_data);
        exp_idx = (exp_idx + 1) % word_count;
        good++;
      end
      prev_data = dac_data;
    end
    assert (good > 0)
      else abort_run($sformatf("case %0s delivered no DAC word at all", case_name));
  endtask

  task automatic run_case();
    $display("case %0s: %0d words, ready duty %0d", case_name, word_count, duty_in);
    @(posedge avl_clk);
    ready_duty <= 8'(duty_in);
    load_waveform();
    wait_for_play();
    check_memory();
    play_and_check();
  endtask

  initial begin
    void'($urandom(32'h04c9_6c9b));
    avl_clk       = 1'b0;
    avl_reset     = 1'b1;
    dma_xfer_req  = 1'b0;
    dma_valid     = 1'b0;
    dma_data      = '0;
    dma_xfer_last = 1'b0;
    dac_valid     = 1'b0;
    fill_req      = 1'b0;
    ready_duty    = 8'd100;
    case_name     = "reset";
    repeat (5) @(posedge avl_clk);
    avl_reset <= 1'b0;
    @(negedge avl_clk);
    assert (avl_read === 1'b0) else flag_mismatch("avl_read after reset", 0, avl_read);
    assert (avl_write === 1'b0) else flag_mismatch("avl_write after reset", 0, avl_write);
    assert (dac_dunf === 1'b0) else flag_mismatch("dac_dunf after reset", 0, dac_dunf);
    assert (dac_xfer_out === 1'b0)
      else flag_mismatch("dac_xfer_out after reset", 0, dac_xfer_out);
    fd = $fopen("test/dacfifo_cases.txt", "r");
    if (fd == 0) begin
      abort_run("cannot open test/dacfifo_cases.txt");
    end
    case_total = 0;
    while ($fgets(line_buf, fd) != 0) begin
      // comment lines do not yield five fields
      if ($sscanf(line_buf, "%s %d %h %d %d", case_name, word_count, first_word, duty_in,
                  req_count) == 5) begin
        run_case();
        case_total++;
      end
    end
    $fclose(fd);
    if (case_total > 0) begin
      $display("NO ERRORS");
      $finish;
    end else begin
      abort_run("the case file holds no cases");
    end
  end

endmodule

/* test/dacfifo_cases.txt */
# name word_count first_word(hex) ready_duty(percent) dac_requests
# words are first_word plus their index, in load order
full_beats 8 00001000 100 40
partial_one 5 a5a50000 100 30
partial_two 6 12340000 90 30
partial_three 7 7f000000 80 40
single_word 1 cafe0000 100 20
single_beat 4 00c0ffee 70 24
long_wave 37 10000000 100 120
low_duty 13 20000000 25 60
low_duty_long 22 30000000 30 80
two_bursts 16 40000000 60 60
odd_tail 9 50000000 50 50
reload_short 2 60000000 100 20
three_words 3 ffffffff 40 30

/* tb.f */
+incdir+src
src/dacfifo_pkg.sv
src/dacfifo_wr.sv
src/dacfifo_rd.sv
src/dacfifo_xfer_ctrl.sv
src/avl_dacfifo.sv
test/avl_mem_model.sv
test/tb_avl_dacfifo.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal -f tb.f \
  --top-module tb_avl_dacfifo -Mdir obj_dir -o sim_avl_dacfifo
./obj_dir/sim_avl_dacfifo | tee sim.log
if grep -q "NO ERRORS" sim.log; then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi
